//--- compile.f
icache_pkg.sv
mem_bus_if.sv
line_ram.sv
cpu_instruction_cache.sv
cpu_data_port.sv
mem_arbiter.sv
main_memory.sv
icache_subsystem.sv
tb_icache_subsystem.sv

//--- Bender.yml
package:
  name: icache_subsystem

sources:
  - icache_pkg.sv
  - mem_bus_if.sv
  - line_ram.sv
  - cpu_instruction_cache.sv
  - cpu_data_port.sv
  - mem_arbiter.sv
  - main_memory.sv
  - icache_subsystem.sv
  - target: test
    files:
      - tb_icache_subsystem.sv

//--- tb_icache_subsystem.sv
`default_nettype none

module tb_icache_subsystem;
	timeunit 1ns;
	timeprecision 100ps;
	import icache_pkg::*;

	logic       CLK = 1'b0;
	logic       RSTb;
	word_addr_t fetch_addr;
	word_t      fetch_data;
	logic       fetch_miss;
	logic       invalidate;
	logic       invalidation_done;
	logic       data_rd;
	logic       data_wr;
	word_addr_t data_addr;
	word_t      data_wdata;
	logic       data_rsp_valid;
	word_t      data_rdata;

	word_t       ref_mem [2**ADDR_BITS];  // Mirror of main memory, zero after reset
	logic [31:0] lfsr = 32'h38135377;
	word_addr_t  exp_addr [$];            // Reads in flight, oldest first
	word_t       exp_data [$];
	int          errors = 0;
	int          checks = 0;
	int          base_errors = 0;         // Errors before the current test

	always #4 CLK = ~CLK;  // 8 ns period

	icache_subsystem icache_subsystem_inst (.*);

	// Fibonacci LFSR with taps 32 22 2 1
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		logic        fb;
		v = '0;
		for (int i = 0; i < n; i++) begin
			fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
			lfsr = {lfsr[30:0], fb};
			v    = {v[30:0], fb};  // One step per bit
		end
		return v;
	endfunction

	// Which pending read owns this data, unknown if none
	function automatic word_addr_t match_addr(input word_t d);
		foreach (exp_data[i])
			if (exp_data[i] === d)
				return exp_addr[i];
		return 'x;
	endfunction

	task automatic check_word(input string what, input word_t got, input word_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("FAIL %0t ns: %s read %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic check_addr(input string what, input word_addr_t got, input word_addr_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("FAIL %0t ns: %s gave address %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic report(input string msg);
		errors++;
		$display("ERROR %0t ns: %s", $time, msg);
	endtask

	task automatic close_test(input string name);
		$display("%-28s %0d errors", name, errors - base_errors);
		base_errors = errors;
	endtask

	// All helpers start and end on a falling edge
	task automatic data_write(input word_addr_t a, input word_t d);
		data_wr    = 1'b1;
		data_addr  = a;
		data_wdata = d;
		ref_mem[a] = d;
		@(negedge CLK);
		data_wr = 1'b0;
		repeat (3) @(negedge CLK);  // Spacing keeps the port buffer shallow
	endtask

	task automatic read_pair(input word_addr_t a0, input word_addr_t a1);
		word_addr_t owner;
		int         wait_cnt;
		exp_addr.push_back(a0);
		exp_data.push_back(ref_mem[a0]);
		exp_addr.push_back(a1);
		exp_data.push_back(ref_mem[a1]);
		data_rd   = 1'b1;  // Back to back strobes
		data_addr = a0;
		@(negedge CLK);
		data_addr = a1;
		@(negedge CLK);
		data_rd  = 1'b0;
		wait_cnt = 0;
		while (exp_addr.size() != 0 && wait_cnt < 40) begin
			if (data_rsp_valid) begin
				owner = match_addr(data_rdata);
				check_addr("read response order", owner, exp_addr[0]);
				check_word("data read", data_rdata, exp_data[0]);
				void'(exp_addr.pop_front());
				void'(exp_data.pop_front());
			end
			@(negedge CLK);
			wait_cnt++;
		end
		if (exp_addr.size() != 0) begin
			report("data read response did not arrive in time");
			exp_addr.delete();
			exp_data.delete();
		end
	endtask

	task automatic fetch_until_hit(input word_addr_t a);
		int wait_cnt;
		fetch_addr = a;
		wait_cnt   = 0;
		do begin
			@(negedge CLK);
			wait_cnt++;
		end while (fetch_miss && wait_cnt < 100);
		if (fetch_miss)
			report($sformatf("fetch of %h still missing after %0d cycles", a, wait_cnt));
		else
			check_word("filled fetch", fetch_data, ref_mem[a]);
	endtask

	// Lookup result is due one cycle after the address
	task automatic fetch_expect_hit(input word_addr_t a, input word_t exp, input string what);
		fetch_addr = a;
		@(negedge CLK);
		if (fetch_miss)
			report($sformatf("%s at %h missed, a hit was expected", what, a));
		else
			check_word(what, fetch_data, exp);
	endtask

	task automatic wait_done(input int limit);
		int wait_cnt;
		int early_hits;
		wait_cnt   = 0;
		early_hits = 0;
		while (!invalidation_done && wait_cnt < limit) begin
			if (!fetch_miss)
				early_hits++;
			@(negedge CLK);
			wait_cnt++;
		end
		if (!invalidation_done)
			report("invalidation_done never pulsed");
		else if (early_hits != 0)
			report("fetch_miss dropped during invalidation");
	endtask

	task automatic run_invalidation();
		invalidate = 1'b1;
		@(negedge CLK);
		invalidate = 1'b0;
		wait_done(300);
	endtask

	task automatic invalidate_after_reset();
		wait_done(300);
		@(negedge CLK);
		if (invalidation_done)
			report("invalidation_done stayed high for more than one cycle");
		close_test("reset invalidation");
	endtask

	task automatic write_then_read_back();
		word_addr_t addrs [20];
		foreach (addrs[i]) begin
			addrs[i] = word_addr_t'(rand_bits(ADDR_BITS));
			data_write(addrs[i], word_t'(rand_bits(DATA_BITS)));
		end
		for (int i = 0; i < 20; i += 2)
			read_pair(addrs[i], addrs[i+1]);
		close_test("data write and read-back");
	endtask

	task automatic fill_and_prefetch();
		word_addr_t bases [3];
		bases = '{15'h1230, 15'h2a40, 15'h5c10};  // Pages the cache has not seen
		foreach (bases[i]) begin
			for (int k = 0; k < 5; k++)
				data_write(word_addr_t'(bases[i] + k), word_t'(rand_bits(DATA_BITS)));
			fetch_until_hit(bases[i]);
			repeat (16) @(negedge CLK);  // Prefetch runs ahead of the fetch
			for (int k = 1; k < 5; k++)
				fetch_expect_hit(word_addr_t'(bases[i] + k), ref_mem[bases[i] + k],
				                 "prefetched fetch");
		end
		close_test("fetch fill");
	endtask

	task automatic refill_after_invalidate();
		word_addr_t a;
		a = fetch_addr;  // Last prefetched word, still cached
		fetch_expect_hit(a, ref_mem[a], "fetch before invalidate");
		run_invalidation();
		@(negedge CLK);
		if (!fetch_miss)
			report("line still hits right after invalidation");
		fetch_until_hit(a);
		close_test("re-invalidation");
	endtask

	task automatic reads_during_fill();
		word_addr_t base;
		word_addr_t addrs [6];
		base = 15'h6e20;
		for (int k = 0; k < 4; k++)
			data_write(word_addr_t'(base + k), word_t'(rand_bits(DATA_BITS)));
		foreach (addrs[i]) begin
			addrs[i] = word_addr_t'(rand_bits(ADDR_BITS));
			data_write(addrs[i], word_t'(rand_bits(DATA_BITS)));  // Distinct words to read back
		end
		fetch_addr = base;  // Miss starts a fill behind the reads
		for (int i = 0; i < 6; i += 2)
			read_pair(addrs[i], addrs[i+1]);
		fetch_until_hit(base);
		repeat (16) @(negedge CLK);
		for (int k = 1; k < 4; k++)
			fetch_expect_hit(word_addr_t'(base + k), ref_mem[base + k], "fetch under contention");
		close_test("contention");
	endtask

	task automatic stale_line_refresh();
		word_addr_t a;
		word_t      old_word;
		a        = 15'h6e21;
		old_word = ref_mem[a];
		fetch_expect_hit(a, old_word, "fetch before data write");
		data_write(a, ~old_word);
		fetch_expect_hit(a, old_word, "stale fetch after data write");  // No coherence
		run_invalidation();
		fetch_until_hit(a);  // Refill brings the new word
		close_test("stale line and refresh");
	endtask

	initial begin
		foreach (ref_mem[i])
			ref_mem[i] = '0;
		RSTb       = 1'b0;
		fetch_addr = '0;
		invalidate = 1'b0;
		data_rd    = 1'b0;
		data_wr    = 1'b0;
		data_addr  = '0;
		data_wdata = '0;
		repeat (2) @(negedge CLK);
		RSTb = 1'b1;
		invalidate_after_reset();
		write_then_read_back();
		fill_and_prefetch();
		refill_after_invalidate();
		reads_during_fill();
		stale_line_refresh();
		$display("6 tests, %0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

endmodule

`default_nettype wire

//--- icache_subsystem.sv
`default_nettype none

module icache_subsystem (
	input  logic                   CLK,
	input  logic                   RSTb,
	input  icache_pkg::word_addr_t fetch_addr,      // Instruction side
	output icache_pkg::word_t      fetch_data,
	output logic                   fetch_miss,
	input  logic                   invalidate,
	output logic                   invalidation_done,
	input  logic                   data_rd,         // Data side strobes
	input  logic                   data_wr,
	input  icache_pkg::word_addr_t data_addr,
	input  icache_pkg::word_t      data_wdata,
	output logic                   data_rsp_valid,
	output icache_pkg::word_t      data_rdata
);

	mem_bus_if icache_bus ();  // Cache to arbiter
	mem_bus_if dport_bus ();   // Data port to arbiter
	mem_bus_if mem_bus ();     // Arbiter to memory

	cpu_instruction_cache cpu_instruction_cache_inst (
		.CLK              (CLK),
		.RSTb             (RSTb),
		.fetch_addr       (fetch_addr),
		.fetch_data       (fetch_data),
		.fetch_miss       (fetch_miss),
		.invalidate       (invalidate),
		.invalidation_done(invalidation_done),
		.bus              (icache_bus.client)
	);

	cpu_data_port cpu_data_port_inst (
		.CLK      (CLK),
		.RSTb     (RSTb),
		.rd       (data_rd),
		.wr       (data_wr),
		.addr     (data_addr),
		.wdata    (data_wdata),
		.rsp_valid(data_rsp_valid),
		.rdata    (data_rdata),
		.bus      (dport_bus.client)
	);

	mem_arbiter mem_arbiter_inst (
		.CLK       (CLK),
		.RSTb      (RSTb),
		.icache_bus(icache_bus.arbiter),
		.dport_bus (dport_bus.arbiter),
		.mem_bus   (mem_bus.client)
	);

	main_memory main_memory_inst (
		.CLK (CLK),
		.RSTb(RSTb),
		.bus (mem_bus.memory)
	);

endmodule

`default_nettype wire

//--- main_memory.sv
`default_nettype none

module main_memory (
	input  logic      CLK,
	input  logic      RSTb,
	mem_bus_if.memory bus
);
	import icache_pkg::*;

	word_t                       mem [2**ADDR_BITS];
	logic [MEM_READ_LATENCY-1:0] rd_valid;   // One bit per pipeline stage
	word_addr_t                  rd_addr_q [MEM_READ_LATENCY];
	word_t                       rd_data_q [MEM_READ_LATENCY];

	// Memory comes up cleared
	initial begin
		for (int i = 0; i < 2**ADDR_BITS; i++)
			mem[i] = '0;
	end

	assign bus.gnt       = bus.req;  // Never stalls
	assign bus.rsp_valid = rd_valid[MEM_READ_LATENCY-1];
	assign bus.rsp_addr  = rd_addr_q[MEM_READ_LATENCY-1];
	assign bus.rsp_data  = rd_data_q[MEM_READ_LATENCY-1];

	// Array and payload stages
	always_ff @(posedge CLK) begin
		if (bus.req && bus.we)
			mem[bus.addr] <= bus.wdata;  // Write lands at the grant
		rd_addr_q[0] <= bus.addr;
		rd_data_q[0] <= mem[bus.addr];
		for (int s = 1; s < MEM_READ_LATENCY; s++) begin
			rd_addr_q[s] <= rd_addr_q[s-1];
			rd_data_q[s] <= rd_data_q[s-1];
		end
	end

	// Read valid pipeline
	always_ff @(posedge CLK) begin
		if (!RSTb)
			rd_valid <= '0;
		else
			rd_valid <= {rd_valid[MEM_READ_LATENCY-2:0], bus.req && !bus.we};
	end

endmodule

`default_nettype wire

//--- mem_arbiter.sv
`default_nettype none

module mem_arbiter (
	input  logic       CLK,
	input  logic       RSTb,
	mem_bus_if.arbiter icache_bus,
	mem_bus_if.arbiter dport_bus,
	mem_bus_if.client  mem_bus
);
	import icache_pkg::*;

	logic                        last_dport;  // Data port won last time
	logic                        pick_dport;
	logic [MEM_READ_LATENCY-1:0] owner_dport; // Owner of each read in flight
	logic                        rsp_dport;

	// Round robin, data port wins unless it won last and the cache waits
	assign pick_dport = dport_bus.req && (!icache_bus.req || !last_dport);

	assign mem_bus.req   = icache_bus.req || dport_bus.req;
	assign mem_bus.we    = pick_dport ? dport_bus.we    : icache_bus.we;
	assign mem_bus.addr  = pick_dport ? dport_bus.addr  : icache_bus.addr;
	assign mem_bus.wdata = pick_dport ? dport_bus.wdata : icache_bus.wdata;

	assign icache_bus.gnt = mem_bus.gnt && icache_bus.req && !pick_dport;
	assign dport_bus.gnt  = mem_bus.gnt && pick_dport;

	// Response steering
	assign rsp_dport            = owner_dport[MEM_READ_LATENCY-1];
	assign icache_bus.rsp_valid = mem_bus.rsp_valid && !rsp_dport;
	assign dport_bus.rsp_valid  = mem_bus.rsp_valid && rsp_dport;
	assign icache_bus.rsp_addr  = mem_bus.rsp_addr;
	assign dport_bus.rsp_addr   = mem_bus.rsp_addr;
	assign icache_bus.rsp_data  = mem_bus.rsp_data;
	assign dport_bus.rsp_data   = mem_bus.rsp_data;

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			last_dport  <= 1'b0;
			owner_dport <= '0;
		end else begin
			if (mem_bus.req && mem_bus.gnt)
				last_dport <= pick_dport;
			// Shifts every cycle, lines up with the memory pipeline
			owner_dport <= {owner_dport[MEM_READ_LATENCY-2:0], pick_dport};
		end
	end

	// One winner, and only when the memory takes the request
	assert property (@(posedge CLK) disable iff (!RSTb)
		(icache_bus.gnt || dport_bus.gnt) |-> (mem_bus.gnt && !(icache_bus.gnt && dport_bus.gnt)));

	// Every granted read comes back to exactly one client
	assert property (@(posedge CLK) disable iff (!RSTb)
		(mem_bus.req && mem_bus.gnt && !mem_bus.we) |->
			##MEM_READ_LATENCY (icache_bus.rsp_valid ^ dport_bus.rsp_valid));

endmodule

`default_nettype wire

//--- cpu_data_port.sv
`default_nettype none

module cpu_data_port (
	input  logic                   CLK,
	input  logic                   RSTb,
	input  logic                   rd,
	input  logic                   wr,
	input  icache_pkg::word_addr_t addr,
	input  icache_pkg::word_t      wdata,
	output logic                   rsp_valid,
	output icache_pkg::word_t      rdata,
	mem_bus_if.client              bus
);
	import icache_pkg::*;

	localparam int PTR_BITS = $clog2(PORT_FIFO_DEPTH);
	localparam int CNT_BITS = $clog2(PORT_FIFO_DEPTH + 1);

	logic       fifo_we    [PORT_FIFO_DEPTH];
	word_addr_t fifo_addr  [PORT_FIFO_DEPTH];
	word_t      fifo_wdata [PORT_FIFO_DEPTH];
	logic [PTR_BITS-1:0] wr_ptr;
	logic [PTR_BITS-1:0] rd_ptr;
	logic [CNT_BITS-1:0] count;
	logic push;
	logic pop;

	assign push = rd || wr;          // CPU strobe, cannot be refused
	assign pop  = bus.req && bus.gnt;

	// Head entry goes out
	assign bus.req   = (count != '0);
	assign bus.we    = fifo_we[rd_ptr];
	assign bus.addr  = fifo_addr[rd_ptr];
	assign bus.wdata = fifo_wdata[rd_ptr];

	// Arbiter steers only our reads back, in order
	assign rsp_valid = bus.rsp_valid;
	assign rdata     = bus.rsp_data;

	always_ff @(posedge CLK) begin
		if (push) begin
			fifo_we[wr_ptr]    <= wr;
			fifo_addr[wr_ptr]  <= addr;
			fifo_wdata[wr_ptr] <= wdata;
		end
	end

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
			count <= count + CNT_BITS'(push) - CNT_BITS'(pop);
		end
	end

	// A full buffer only takes a strobe while its head is granted
	assert property (@(posedge CLK) disable iff (!RSTb)
		push |-> ((count < CNT_BITS'(PORT_FIFO_DEPTH)) || pop));

	assert property (@(posedge CLK) disable iff (!RSTb) !(rd && wr));

endmodule

`default_nettype wire

//--- cpu_instruction_cache.sv
`default_nettype none

module cpu_instruction_cache (
	input  logic                   CLK,
	input  logic                   RSTb,
	input  icache_pkg::word_addr_t fetch_addr,
	output icache_pkg::word_t      fetch_data,
	output logic                   fetch_miss,
	input  logic                   invalidate,
	output logic                   invalidation_done,
	mem_bus_if.client              bus
);
	import icache_pkg::*;

	logic [1:0]  state;
	line_idx_t   sweep_idx;        // Line being cleared
	word_addr_t  fetch_addr_q;     // Address matching the RAM output
	word_addr_t  fill_addr;        // Next word to request
	word_addr_t  miss_addr_q;      // Last miss that reloaded the pointer
	logic        miss_seen;
	cache_line_u rd_line;
	cache_line_u wr_line;
	line_idx_t   wr_idx;
	logic        wr_en;
	logic        line_miss;
	logic        reload;

	line_ram #(
		.BITS        ($bits(cache_line_u)),
		.ADDRESS_BITS(CACHE_DEPTH_BITS)
	) line_ram_inst (
		.CLK    (CLK),
		.rd_addr(fetch_addr[CACHE_DEPTH_BITS-1:0]),  // Read with the same edge
		.rd_data(rd_line),
		.wr     (wr_en),
		.wr_addr(wr_idx),
		.wr_data(wr_line)
	);

	// Lookup
	assign line_miss         = (rd_line.fields.tag != fetch_addr_q) || rd_line.fields.invalid;
	assign fetch_miss        = (state != ST_EXECUTE) || line_miss;
	assign fetch_data        = rd_line.fields.data;
	assign invalidation_done = (state == ST_DONE);

	// Read requests only, all the time in execute
	assign bus.req   = (state == ST_EXECUTE);
	assign bus.we    = 1'b0;
	assign bus.addr  = fill_addr;
	assign bus.wdata = '0;

	// Reload only on a grant, so a pending address never changes
	assign reload = (state == ST_EXECUTE) && line_miss &&
	                !(miss_seen && (miss_addr_q == fetch_addr_q)) &&
	                bus.gnt;

	// Line write source
	always_comb begin
		wr_en   = 1'b0;
		wr_idx  = sweep_idx;
		wr_line = '0;
		if (state == ST_INVALIDATE) begin
			wr_en       = 1'b1;
			wr_line.raw = '1;  // Invalid pattern
		end else if ((state == ST_EXECUTE) && bus.rsp_valid) begin
			wr_en                  = 1'b1;
			wr_idx                 = bus.rsp_addr[CACHE_DEPTH_BITS-1:0];
			wr_line.fields.tag     = bus.rsp_addr;
			wr_line.fields.invalid = 1'b0;
			wr_line.fields.data    = bus.rsp_data;
		end
	end

	// FSM and sweep counter
	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			state     <= ST_INIT;
			sweep_idx <= '0;
		end else begin
			case (state)
				ST_INIT: begin
					sweep_idx <= '0;
					state     <= ST_INVALIDATE;
				end
				ST_INVALIDATE: begin
					sweep_idx <= sweep_idx + 1'b1;
					if (sweep_idx == '1)
						state <= ST_DONE;  // Last line written
				end
				ST_DONE:
					state <= ST_EXECUTE;
				default:
					if (invalidate)
						state <= ST_INIT;  // Same sequence as after reset
			endcase
		end
	end

	// Fill pointer
	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			fetch_addr_q <= '0;
			fill_addr    <= '0;
			miss_addr_q  <= '0;
			miss_seen    <= 1'b0;
		end else begin
			fetch_addr_q <= fetch_addr;
			if (state != ST_EXECUTE) begin
				miss_seen <= 1'b0;  // Every miss is new after a sweep
			end else if (reload) begin
				fill_addr   <= fetch_addr_q;
				miss_addr_q <= fetch_addr_q;
				miss_seen   <= 1'b1;
			end else if (bus.gnt && (fill_addr[CACHE_DEPTH_BITS-1:0] != '1)) begin
				fill_addr <= fill_addr + 1'b1;  // Prefetch to end of page
			end
		end
	end

	// Quiet bus through the whole invalidation sequence
	assert property (@(posedge CLK) disable iff (!RSTb)
		(state == ST_EXECUTE && invalidate) |=> !bus.req [*(2**CACHE_DEPTH_BITS + 2)]);

	// Pending request keeps its address unless an invalidation drops it
	assert property (@(posedge CLK) disable iff (!RSTb)
		(bus.req && !bus.gnt && !invalidate) |=> (bus.req && $stable(bus.addr)));

endmodule

`default_nettype wire

//--- line_ram.sv
`default_nettype none

module line_ram #(
	parameter int BITS         = 32,
	parameter int ADDRESS_BITS = 8
) (
	input  logic                    CLK,
	input  logic [ADDRESS_BITS-1:0] rd_addr,
	output logic [BITS-1:0]         rd_data,
	input  logic                    wr,
	input  logic [ADDRESS_BITS-1:0] wr_addr,
	input  logic [BITS-1:0]         wr_data
);

	logic [BITS-1:0] mem [2**ADDRESS_BITS];

	// Read before write on a collision
	always_ff @(posedge CLK) begin
		if (wr)
			mem[wr_addr] <= wr_data;
		rd_data <= mem[rd_addr];  // Registered read port
	end

endmodule

`default_nettype wire

//--- mem_bus_if.sv
`default_nettype none

interface mem_bus_if;
	import icache_pkg::*;

	logic       req;        // Held until gnt
	logic       we;         // High for a write, low for a read
	word_addr_t addr;
	word_t      wdata;
	logic       gnt;        // Request taken this cycle
	logic       rsp_valid;  // Read data, two cycles after the grant
	word_addr_t rsp_addr;   // Address of the returning read
	word_t      rsp_data;

	modport client  (output req, we, addr, wdata,
	                 input  gnt, rsp_valid, rsp_addr, rsp_data);

	modport arbiter (input  req, we, addr, wdata,
	                 output gnt, rsp_valid, rsp_addr, rsp_data);

	modport memory  (input  req, we, addr, wdata,
	                 output gnt, rsp_valid, rsp_addr, rsp_data);

endinterface

`default_nettype wire

//--- icache_pkg.sv
`default_nettype none

package icache_pkg;

	// Memory geometry
	localparam int ADDR_BITS        = 15;    // Word address width
	localparam int DATA_BITS        = 16;    // CPU word width
	localparam int CACHE_DEPTH_BITS = 8;     // 256 lines
	localparam int MEM_READ_LATENCY = 2;     // Grant to response, in cycles
	localparam int PORT_FIFO_DEPTH  = 2;     // Data port request buffer

	// Cache FSM encodings
	localparam logic [1:0] ST_INIT       = 2'd0;
	localparam logic [1:0] ST_INVALIDATE = 2'd1;
	localparam logic [1:0] ST_DONE       = 2'd2;
	localparam logic [1:0] ST_EXECUTE    = 2'd3;

	typedef logic [ADDR_BITS-1:0]        word_addr_t;
	typedef logic [DATA_BITS-1:0]        word_t;
	typedef logic [CACHE_DEPTH_BITS-1:0] line_idx_t;

	// Tag holds the full word address, so the index bits repeat in it
	typedef struct packed {
		word_addr_t tag;
		logic       invalid;  // Set means the line holds nothing
		word_t      data;
	} cache_line_fields_t;

	// All ones is an invalid line
	typedef union packed {
		logic [ADDR_BITS+DATA_BITS:0] raw;
		cache_line_fields_t           fields;
	} cache_line_u;

endpackage

`default_nettype wire
